//--- include/exu_defs.svh
`ifndef EXU_DEFS_SVH
`define EXU_DEFS_SVH

// datapath width
`define EXU_XLEN 32

// rv32i major opcodes, inst[6:0]
`define EXU_OP_OP_IMM   7'b0010011  // addi, slti, shifts ...
`define EXU_OP_OP       7'b0110011  // register-register alu
`define EXU_OP_LOAD     7'b0000011
`define EXU_OP_STORE    7'b0100011
`define EXU_OP_JAL      7'b1101111
`define EXU_OP_JALR     7'b1100111
`define EXU_OP_AUIPC    7'b0010111
`define EXU_OP_LUI      7'b0110111
`define EXU_OP_BRANCH   7'b1100011
`define EXU_OP_SYSTEM   7'b1110011  // csr ops and traps
`define EXU_OP_MISC_MEM 7'b0001111  // fence / fence.i

// store width in funct3
`define EXU_F3_SB 3'b000
`define EXU_F3_SH 3'b001
`define EXU_F3_SW 3'b010

// trap / csr codes handed to the csr unit
`define EXU_TRAP_MRET   3'b001
`define EXU_TRAP_ECALL  3'b010
`define EXU_TRAP_EBREAK 3'b011
`define EXU_TRAP_CSRW   3'b100  // csrrw or csrrs write-back

`endif

//--- src/exu_pkg.sv
`include "exu_defs.svh"

package exu_pkg;

  typedef logic [`EXU_XLEN-1:0] xlen_t;   // one data word
  typedef logic [6:0]           opcode_t;
  typedef logic [2:0]           funct3_t;
  typedef logic [4:0]           reg_idx_t;
  typedef logic [3:0]           alu_op_t;  // [3] branch compare, [2:0] funct3
  typedef logic [2:0]           csr_op_t;  // trap / csr code
  typedef logic [3:0]           wmask_t;   // byte lanes of a store

  // bundle from register read
  typedef struct packed {
    opcode_t  op;
    funct3_t  func;
    xlen_t    imm;        // already sign extended
    xlen_t    pc;
    xlen_t    src1;
    xlen_t    src2;
    xlen_t    csr_rdata;
    reg_idx_t rd;
  } exu_issue_t;

  // decoded controls
  typedef struct packed {
    xlen_t   alu_a;
    xlen_t   alu_b;
    alu_op_t alu_op;
    logic    sub;         // adder subtracts
    logic    sign;        // signed compare or arithmetic shift
    logic    reg_wen;
    logic    mem_wen;
    logic    mem_ren;
    wmask_t  wmask;
    funct3_t load_ctrl;
    logic    csr_wen;
    csr_op_t csr_op;
    logic    jump;        // jal, jalr and traps
    logic    is_branch;
    logic    csr_target;  // target comes from csr unit
    logic    fencei;
    logic    wb_sel;      // 1 picks csr_rdata
    xlen_t   target;      // jump target, also lsu address
  } exu_ctrl_t;

  // bundle to memory / writeback
  typedef struct packed {
    xlen_t    pc;
    reg_idx_t rd;
    logic     reg_wen;
    xlen_t    wb_data;
    logic     mem_ren;
    logic     mem_wen;
    xlen_t    lsu_addr;
    xlen_t    store_data;
    wmask_t   wmask;
    funct3_t  load_ctrl;
    logic     csr_wen;
    csr_op_t  csr_op;
    xlen_t    csr_wdata;
    logic     redirect;
    xlen_t    redirect_pc;
    logic     redirect_csr;
    logic     fencei;
  } exu_result_t;

endpackage

//--- src/exu_issue_reg.sv
`timescale 1ns/1ns

module exu_issue_reg (
  input  logic                clock,
  input  logic                reset,
  input  logic                in_valid,
  output logic                in_ready,
  input  exu_pkg::exu_issue_t issue,
  input  logic                advance,     // held bundle moves on this cycle
  output logic                held_valid,
  output exu_pkg::exu_issue_t held
);
  import exu_pkg::*;

  logic load;  // accept edge

  // free slot or slot draining this cycle
  assign in_ready = !held_valid || advance;
  assign load     = in_valid && in_ready;

  always_ff @(posedge clock) begin
    if (reset) begin
      held_valid <= 1'b0;
    end else if (in_ready) begin
      held_valid <= in_valid;  // refill or go empty
    end
  end

  // bundle captured on the accept edge
  always_ff @(posedge clock) begin
    if (load) begin
      held <= issue;
    end
  end

  // stalled bundle must not change under decode
  held_stable_a: assert property (
    @(posedge clock) disable iff (reset)
    held_valid && !advance |=> held_valid && $stable(held)
  ) else $error("issue reg: held bundle changed while stalled");

endmodule

//--- src/exu_decode.sv
`timescale 1ns/1ns
`include "exu_defs.svh"

module exu_decode (
  input  exu_pkg::exu_issue_t held,
  output exu_pkg::exu_ctrl_t  ctrl
);
  import exu_pkg::*;

  logic is_opimm;
  logic is_op;
  logic is_load;
  logic is_store;
  logic is_jal;
  logic is_jalr;
  logic is_auipc;
  logic is_lui;
  logic is_branch;
  logic is_system;
  logic is_misc;
  logic arith_sh;     // sra / srai
  xlen_t base;        // pc or src1 for the target adder
  xlen_t sum;
  wmask_t store_mask;

  assign is_opimm  = held.op == `EXU_OP_OP_IMM;
  assign is_op     = held.op == `EXU_OP_OP;
  assign is_load   = held.op == `EXU_OP_LOAD;
  assign is_store  = held.op == `EXU_OP_STORE;
  assign is_jal    = held.op == `EXU_OP_JAL;
  assign is_jalr   = held.op == `EXU_OP_JALR;
  assign is_auipc  = held.op == `EXU_OP_AUIPC;
  assign is_lui    = held.op == `EXU_OP_LUI;
  assign is_branch = held.op == `EXU_OP_BRANCH;
  assign is_system = held.op == `EXU_OP_SYSTEM;
  assign is_misc   = held.op == `EXU_OP_MISC_MEM;

  // funct7[5] sits in imm[5] for r-type, in imm[10] for shift immediates
  assign arith_sh = (held.func == 3'b101) &&
                    ((is_op && held.imm[5]) || (is_opimm && held.imm[10]));

  // alu operands
  assign ctrl.alu_a = (is_jal || is_jalr || is_auipc) ? held.pc :
                      is_lui ? '0 : held.src1;
  assign ctrl.alu_b = (is_opimm || is_load || is_store || is_auipc || is_lui) ? held.imm :
                      (is_jal || is_jalr) ? xlen_t'(4) :          // link = pc + 4
                      (is_system && held.func == 3'b001) ? '0 :   // csrrw passes src1
                      (is_system && held.func == 3'b010) ? held.csr_rdata :  // csrrs
                      held.src2;                                  // r-type, branch
  assign ctrl.alu_op = (is_opimm || is_op) ? {1'b0, held.func} :
                       is_branch ? {1'b1, held.func} :
                       (is_system && held.func == 3'b010) ? 4'b0110 :  // or for csrrs
                       4'b0000;                                        // plain add
  // subtract for slt(u), branches and r-type sub
  assign ctrl.sub = ((is_opimm || is_op) && (held.func == 3'b010 || held.func == 3'b011)) ||
                    is_branch || (is_op && held.func == 3'b000 && held.imm[5]);
  assign ctrl.sign = ((is_opimm || is_op) && held.func == 3'b010) ||
                     (is_branch && (held.func == 3'b100 || held.func == 3'b101)) ||
                     arith_sh;

  // register / memory side
  assign ctrl.reg_wen   = !(is_store || is_branch || is_misc);
  assign ctrl.mem_wen   = is_store;
  assign ctrl.mem_ren   = is_load;
  assign ctrl.load_ctrl = is_load ? held.func : '0;
  assign ctrl.wmask     = store_mask;

  always_comb begin
    store_mask = '0;
    if (is_store) begin
      case (held.func)
        `EXU_F3_SB: store_mask = 4'b0001;
        `EXU_F3_SH: store_mask = 4'b0011;
        `EXU_F3_SW: store_mask = 4'b1111;
        default:    store_mask = 4'b1111;  // treat odd widths as word
      endcase
    end
  end

  // csr unit and trap codes, trap kind from imm bits
  assign ctrl.csr_wen = is_system;
  assign ctrl.csr_op  = !is_system ? 3'b000 :
                        (held.func == 3'b000) ?
                          (held.imm[1] ? `EXU_TRAP_MRET :
                           !held.imm[0] ? `EXU_TRAP_ECALL : `EXU_TRAP_EBREAK) :
                        (held.func == 3'b001 || held.func == 3'b010) ? `EXU_TRAP_CSRW :
                        3'b000;
  assign ctrl.wb_sel     = is_system;
  assign ctrl.csr_target = is_system && held.func == 3'b000;

  // control flow
  assign ctrl.jump      = is_jal || is_jalr || (is_system && held.func == 3'b000);
  assign ctrl.is_branch = is_branch;
  assign ctrl.fencei    = is_misc && held.func == 3'b001;

  // one adder for branch / jump targets and lsu address
  assign base        = (is_jal || is_branch) ? held.pc : held.src1;
  assign sum         = base + held.imm;
  assign ctrl.target = is_jalr ? {sum[$bits(xlen_t)-1:1], 1'b0} : sum;

  // loads and stores use disjoint opcodes
  mem_excl_a: assert final ($isunknown(held.op) || !(ctrl.mem_wen && ctrl.mem_ren))
    else $error("decode: load and store both set");

endmodule

//--- src/exu_alu.sv
`timescale 1ns/1ns

module exu_alu (
  input  exu_pkg::exu_ctrl_t ctrl,
  output exu_pkg::xlen_t     alu_result,
  output logic               cmp_true    // branch condition holds
);
  import exu_pkg::*;

  localparam int MSB = $bits(xlen_t) - 1;
  localparam int SHW = $clog2($bits(xlen_t));

  xlen_t a;
  xlen_t b_x;                  // b inverted when subtracting
  xlen_t sum;
  logic  carry;
  logic  ovf;
  logic  lt;                   // a < b signed or unsigned per ctrl.sign
  logic  eq;
  logic [SHW-1:0] shamt;

  assign a     = ctrl.alu_a;
  assign b_x   = ctrl.sub ? ~ctrl.alu_b : ctrl.alu_b;
  assign shamt = ctrl.alu_b[SHW-1:0];

  // a + b or a - b with carry kept for unsigned compare
  assign {carry, sum} = {1'b0, a} + {1'b0, b_x} + {{$bits(xlen_t){1'b0}}, ctrl.sub};

  // signed overflow of the subtraction
  assign ovf = (a[MSB] == b_x[MSB]) && (sum[MSB] != a[MSB]);
  // no borrow out means a >= b unsigned
  assign lt  = ctrl.sign ? (sum[MSB] ^ ovf) : !carry;
  assign eq  = sum == '0;     // a - b == 0

  always_comb begin
    case (ctrl.alu_op[2:0])
      3'b000: alu_result = sum;                        // add / sub
      3'b001: alu_result = a << shamt;                 // sll
      3'b010, 3'b011: alu_result = xlen_t'(lt);        // slt / sltu by ctrl.sign
      3'b100: alu_result = a ^ ctrl.alu_b;
      3'b101: begin
        if (ctrl.sign) begin
          alu_result = xlen_t'($signed(a) >>> shamt);  // sra
        end else begin
          alu_result = a >> shamt;                     // srl
        end
      end
      3'b110: alu_result = a | ctrl.alu_b;
      default: alu_result = a & ctrl.alu_b;
    endcase
  end

  // branch compare on funct3 in the low bits
  always_comb begin
    cmp_true = 1'b0;
    if (ctrl.alu_op[3]) begin
      case (ctrl.alu_op[2:0])
        3'b000:          cmp_true = eq;   // beq
        3'b001:          cmp_true = !eq;  // bne
        3'b100, 3'b110:  cmp_true = lt;   // blt, bltu
        3'b101, 3'b111:  cmp_true = !lt;  // bge, bgeu
        default:         cmp_true = 1'b0;
      endcase
    end
  end

endmodule

//--- src/exu_commit.sv
`timescale 1ns/1ns
`include "exu_defs.svh"

module exu_commit (
  input  logic                 clock,
  input  logic                 reset,
  input  logic                 held_valid,
  input  exu_pkg::exu_issue_t  held,
  input  exu_pkg::exu_ctrl_t   ctrl,
  input  exu_pkg::xlen_t       alu_result,
  input  logic                 cmp_true,
  output logic                 advance,
  output logic                 out_valid,
  input  logic                 out_ready,
  output exu_pkg::exu_result_t result
);
  import exu_pkg::*;

  exu_result_t next_result;

  // output slot empty or drained this cycle
  assign advance = held_valid && (!out_valid || out_ready);

  always_comb begin
    next_result.pc           = held.pc;
    next_result.rd           = held.rd;
    next_result.reg_wen      = ctrl.reg_wen;
    next_result.wb_data      = ctrl.wb_sel ? held.csr_rdata : alu_result;  // csr reads old value
    next_result.mem_ren      = ctrl.mem_ren;
    next_result.mem_wen      = ctrl.mem_wen;
    next_result.lsu_addr     = ctrl.target;    // src1 + imm for loads and stores
    next_result.store_data   = held.src2;
    next_result.wmask        = ctrl.wmask;
    next_result.load_ctrl    = ctrl.load_ctrl;
    next_result.csr_wen      = ctrl.csr_wen;
    next_result.csr_op       = ctrl.csr_op;
    // new csr value only for csrrw / csrrs
    next_result.csr_wdata    = (ctrl.csr_op == `EXU_TRAP_CSRW) ? alu_result : '0;
    next_result.redirect     = ctrl.jump || (ctrl.is_branch && cmp_true);
    next_result.redirect_pc  = ctrl.target;
    next_result.redirect_csr = ctrl.csr_target;  // mret / ecall / ebreak
    next_result.fencei       = ctrl.fencei;
  end

  always_ff @(posedge clock) begin
    if (reset) begin
      out_valid <= 1'b0;
    end else if (advance) begin
      out_valid <= 1'b1;    // refill, also on same-edge read
    end else if (out_ready) begin
      out_valid <= 1'b0;
    end
  end

  always_ff @(posedge clock) begin
    if (advance) begin
      result <= next_result;
    end
  end

  // stalled output holds, nothing dropped or replaced
  result_hold_a: assert property (
    @(posedge clock) disable iff (reset)
    out_valid && !out_ready |=> out_valid && $stable(result)
  ) else $error("commit: result changed under back-pressure");

endmodule

//--- src/exu_top.sv
`timescale 1ns/1ns

module exu_top (
  input  logic                 clock,
  input  logic                 reset,
  input  logic                 in_valid,
  output logic                 in_ready,
  input  exu_pkg::exu_issue_t  issue,
  output logic                 out_valid,
  input  logic                 out_ready,
  output exu_pkg::exu_result_t result
);
  import exu_pkg::*;

  logic       held_valid;
  logic       advance;     // issue reg -> commit reg
  logic       cmp_true;
  exu_issue_t held;
  exu_ctrl_t  ctrl;
  xlen_t      alu_result;

  // stage 1, input register
  exu_issue_reg u_issue_reg (
    .clock      (clock),
    .reset      (reset),
    .in_valid   (in_valid),
    .in_ready   (in_ready),
    .issue      (issue),
    .advance    (advance),
    .held_valid (held_valid),
    .held       (held)
  );

  exu_decode u_decode (
    .held (held),
    .ctrl (ctrl)
  );

  exu_alu u_alu (
    .ctrl       (ctrl),
    .alu_result (alu_result),
    .cmp_true   (cmp_true)
  );

  // stage 2, resolve and register result
  exu_commit u_commit (
    .clock      (clock),
    .reset      (reset),
    .held_valid (held_valid),
    .held       (held),
    .ctrl       (ctrl),
    .alu_result (alu_result),
    .cmp_true   (cmp_true),
    .advance    (advance),
    .out_valid  (out_valid),
    .out_ready  (out_ready),
    .result     (result)
  );

endmodule

//--- sim/exu_tb.sv
`timescale 1ns/1ns
`include "exu_defs.svh"

module exu_tb;
  import exu_pkg::*;

  localparam int N_INSTR = 300;
  localparam int N_FLOW  = 100;              // first instructions run without gaps
  localparam int LIMIT   = N_INSTR * 8 + 50; // cycles

  logic        clock;
  logic        reset;
  logic        in_valid;
  logic        in_ready;
  exu_issue_t  issue;
  logic        out_valid;
  logic        out_ready;
  exu_result_t result;

  logic [31:0] seed = 32'd44851;
  int          n_driven = 0;    // bundles put on the input
  int          n_accepted = 0;  // bundles taken by the DUT
  int          cycles = 0;
  string       cur_name;
  exu_result_t exp_q[$];        // expected results, oldest first
  string       name_q[$];

  exu_top DUT (
    .clock     (clock),
    .reset     (reset),
    .in_valid  (in_valid),
    .in_ready  (in_ready),
    .issue     (issue),
    .out_valid (out_valid),
    .out_ready (out_ready),
    .result    (result)
  );

  initial begin
    clock = 1'b0;
    forever #50 clock = ~clock;
  end

  task automatic report_failure(input string msg);
    $display("%s", msg);
    $display("SIMULATION FAILED");
    $fatal(1, "stopping at first error");
  endtask

  function automatic logic [31:0] next_rand();
    seed = seed * 32'd1103515245 + 32'd12345;
    return seed;
  endfunction

  function automatic int pick(int n);
    return int'(next_rand() >> 16) % n;  // upper lcg bits only
  endfunction

  function automatic xlen_t rand_word();
    int k;
    k = pick(4);
    if (k == 0) return xlen_t'(pick(16));                  // small values
    if (k == 1) return 32'h8000_0000 | xlen_t'(pick(16));  // near the signed minimum
    return (next_rand() & 32'hffff_0000) | (next_rand() >> 16);
  endfunction

  // expected result from the rv32i meaning of the bundle
  function automatic exu_result_t ref_result(exu_issue_t i);
    exu_result_t e;
    xlen_t b;
    xlen_t alu;
    logic signed [31:0] sa;
    logic [4:0] sh;
    logic take;
    e = '0;
    e.pc = i.pc;
    e.rd = i.rd;
    sa = i.src1;
    b = (i.op == `EXU_OP_OP) ? i.src2 : i.imm;
    sh = b[4:0];
    case (i.func)
      3'd0: alu = (i.op == `EXU_OP_OP && i.imm[5]) ? i.src1 - b : i.src1 + b;  // funct7[5] = sub
      3'd1: alu = i.src1 << sh;
      3'd2: alu = xlen_t'($signed(i.src1) < $signed(b));
      3'd3: alu = xlen_t'(i.src1 < b);
      3'd4: alu = i.src1 ^ b;
      3'd5: begin
        if (i.op == `EXU_OP_OP ? i.imm[5] : i.imm[10]) begin
          alu = sa >>> sh;        // sra / srai
        end else begin
          alu = i.src1 >> sh;
        end
      end
      3'd6: alu = i.src1 | b;
      default: alu = i.src1 & b;
    endcase
    case (i.func)
      3'd0: take = i.src1 == i.src2;
      3'd1: take = i.src1 != i.src2;
      3'd4: take = $signed(i.src1) < $signed(i.src2);
      3'd5: take = $signed(i.src1) >= $signed(i.src2);
      3'd6: take = i.src1 < i.src2;
      default: take = i.src1 >= i.src2;
    endcase
    case (i.op)
      `EXU_OP_OP, `EXU_OP_OP_IMM: begin
        e.reg_wen = 1'b1;
        e.wb_data = alu;
      end
      `EXU_OP_LOAD: begin
        e.reg_wen = 1'b1;
        e.mem_ren = 1'b1;
        e.lsu_addr = i.src1 + i.imm;
        e.load_ctrl = i.func;
      end
      `EXU_OP_STORE: begin
        e.mem_wen = 1'b1;
        e.lsu_addr = i.src1 + i.imm;
        e.store_data = i.src2;
        e.wmask = (i.func == `EXU_F3_SB) ? 4'b0001 : (i.func == `EXU_F3_SH) ? 4'b0011 : 4'b1111;
      end
      `EXU_OP_BRANCH: begin
        e.redirect = take;
        e.redirect_pc = i.pc + i.imm;
      end
      `EXU_OP_JAL, `EXU_OP_JALR: begin
        e.reg_wen = 1'b1;
        e.wb_data = i.pc + 32'd4;  // link address
        e.redirect = 1'b1;
        e.redirect_pc = (i.op == `EXU_OP_JAL) ? i.pc + i.imm : (i.src1 + i.imm) & ~32'd1;
      end
      `EXU_OP_AUIPC: begin
        e.reg_wen = 1'b1;
        e.wb_data = i.pc + i.imm;
      end
      `EXU_OP_LUI: begin
        e.reg_wen = 1'b1;
        e.wb_data = i.imm;
      end
      `EXU_OP_SYSTEM: begin
        e.reg_wen = 1'b1;
        e.wb_data = i.csr_rdata;   // old csr value
        e.csr_wen = 1'b1;
        if (i.func == 3'b000) begin
          e.csr_op = (i.imm == 32'h302) ? `EXU_TRAP_MRET :
                     (i.imm == 32'h1) ? `EXU_TRAP_EBREAK : `EXU_TRAP_ECALL;
          e.redirect = 1'b1;
          e.redirect_csr = 1'b1;
        end else begin
          e.csr_op = `EXU_TRAP_CSRW;
          e.csr_wdata = (i.func == 3'b010) ? i.src1 | i.csr_rdata : i.src1;
        end
      end
      default: e.fencei = i.func == 3'b001;  // fence / fence.i
    endcase
    return e;
  endfunction

  // clear fields that carry no meaning for this instruction
  function automatic exu_result_t mask_dont_care(exu_result_t r, exu_result_t e);
    exu_result_t m;
    m = r;
    if (!e.reg_wen || e.mem_ren) m.wb_data = '0;  // load data comes later
    if (!e.mem_ren && !e.mem_wen) m.lsu_addr = '0;
    if (!e.mem_wen) m.store_data = '0;
    if (e.csr_op != `EXU_TRAP_CSRW) m.csr_wdata = '0;
    if (!e.redirect || e.redirect_csr) m.redirect_pc = '0;  // trap target from csr unit
    return m;
  endfunction

  task automatic make_instr(output exu_issue_t i, output string name);
    logic [31:0] r;
    int v;
    i = '0;
    r = next_rand();
    i.pc        = 32'h8000_0000 + 32'(n_driven) * 4;  // unique per instruction
    i.src1      = rand_word();
    i.src2      = (pick(5) == 0) ? i.src1 : rand_word();  // equal operands now and then
    i.csr_rdata = rand_word();
    i.rd        = reg_idx_t'(pick(32));
    i.imm       = {{20{r[27]}}, r[27:16]};                 // 12-bit signed immediate
    case (pick(11))
      0: begin
        i.op   = `EXU_OP_OP;
        i.func = funct3_t'(pick(8));
        i.imm  = (pick(2) == 0) ? 32'd32 : 32'd0;   // funct7[5]
        name   = "r_type";
      end
      1: begin
        i.op   = `EXU_OP_OP_IMM;
        i.func = funct3_t'(pick(8));
        if (i.func == 3'b001 || i.func == 3'b101) begin
          i.imm = xlen_t'(pick(32)) | ((i.func == 3'b101 && pick(2) == 0) ? 32'h400 : 32'h0);
        end
        name   = "i_type";
      end
      2: begin
        v      = pick(5);
        i.op   = `EXU_OP_LOAD;
        i.func = funct3_t'(v > 2 ? v + 1 : v);  // lb lh lw lbu lhu
        name   = "load";
      end
      3: begin
        i.op   = `EXU_OP_STORE;
        i.func = funct3_t'(pick(3));
        name   = "store";
      end
      4: begin
        v      = pick(6);
        i.op   = `EXU_OP_BRANCH;
        i.func = funct3_t'(v > 1 ? v + 2 : v);  // skip the two unused codes
        name   = "branch";
      end
      5: begin
        i.op = `EXU_OP_JAL;
        name = "jal";
      end
      6: begin
        i.op = `EXU_OP_JALR;
        name = "jalr";
      end
      7: begin
        i.op  = (pick(2) == 0) ? `EXU_OP_AUIPC : `EXU_OP_LUI;
        i.imm = {r[31:12], 12'b0};
        name  = (i.op == `EXU_OP_AUIPC) ? "auipc" : "lui";
      end
      8: begin
        i.op   = `EXU_OP_SYSTEM;
        i.func = funct3_t'(1 + pick(2));
        name   = (i.func == 3'b001) ? "csrrw" : "csrrs";
      end
      9: begin
        v      = pick(3);
        i.op   = `EXU_OP_SYSTEM;
        i.imm  = (v == 0) ? 32'h302 : xlen_t'(v - 1);  // funct12 of mret / ecall / ebreak
        name   = (v == 0) ? "mret" : (v == 1) ? "ecall" : "ebreak";
      end
      default: begin
        i.op   = `EXU_OP_MISC_MEM;
        i.func = funct3_t'(pick(2));
        name   = (i.func == 3'b001) ? "fence_i" : "fence";
      end
    endcase
  endtask

  // scoreboard, compares on the output handshake and books accepted bundles
  always @(posedge clock) begin
    cycles = cycles + 1;
    if (cycles > LIMIT) report_failure($sformatf("Timeout after %0d cycles", LIMIT));
    if (!reset && out_valid && out_ready) begin
      assert (exp_q.size() > 0)
        else report_failure("Result handed out with no instruction outstanding");
      assert (mask_dont_care(result, exp_q[0]) == mask_dont_care(exp_q[0], exp_q[0]))
        else report_failure($sformatf("Mismatch %s pc %h expected %h actual %h", name_q[0],
          exp_q[0].pc, mask_dont_care(exp_q[0], exp_q[0]), mask_dont_care(result, exp_q[0])));
      void'(exp_q.pop_front());
      void'(name_q.pop_front());
    end
    if (!reset && in_valid && in_ready) begin
      exp_q.push_back(ref_result(issue));
      name_q.push_back(cur_name);
      n_accepted = n_accepted + 1;
    end
  end

  // stalled result stays put
  result_hold_a: assert property (
    @(posedge clock) disable iff (reset)
    out_valid && !out_ready |=> out_valid && $stable(result)
  ) else report_failure("Result changed or dropped while out_ready was low");

  // accept, then a free output slot, gives the result one edge later
  latency_a: assert property (
    @(posedge clock) disable iff (reset)
    in_valid && in_ready ##1 out_ready |=> out_valid && result.pc == $past(issue.pc, 2)
  ) else report_failure("Accepted instruction did not reach the output two edges later");

  initial begin
    reset     = 1'b1;
    in_valid  = 1'b0;
    out_ready = 1'b0;
    issue     = '0;
    cur_name  = "none";
    repeat (5) @(posedge clock);
    @(negedge clock);
    reset = 1'b0;
    assert (!out_valid && in_ready)
      else report_failure("Handshake outputs not idle after reset");
    while (n_accepted < N_INSTR) begin
      @(negedge clock);
      if (n_accepted == n_driven) begin  // nothing pending on the input
        if (n_driven < N_INSTR && (n_driven < N_FLOW || pick(4) != 0)) begin
          make_instr(issue, cur_name);
          in_valid = 1'b1;
          n_driven = n_driven + 1;
        end else begin
          in_valid = 1'b0;                // gap
        end
      end
      out_ready = (n_driven <= N_FLOW) ? 1'b1 : (pick(4) != 0);
    end
    out_ready = 1'b1;                     // drain
    while (exp_q.size() > 0) begin
      @(negedge clock);
    end
    @(negedge clock);
    if (exp_q.size() == 0 && !out_valid) begin
      $display("SIMULATION PASSED");
      $finish;
    end else begin
      report_failure("Instructions left outstanding at the end of the run");
    end
  end

endmodule

//--- files.f
+incdir+include
src/exu_pkg.sv
src/exu_issue_reg.sv
src/exu_decode.sv
src/exu_alu.sv
src/exu_commit.sv
src/exu_top.sv
sim/exu_tb.sv

//--- Bender.yml
package:
  name: exu

sources:
  - include_dirs:
      - include
    files:
      - src/exu_pkg.sv
      - src/exu_issue_reg.sv
      - src/exu_decode.sv
      - src/exu_alu.sv
      - src/exu_commit.sv
      - src/exu_top.sv
  - target: test
    include_dirs:
      - include
    files:
      - sim/exu_tb.sv
